/* verilog/cpuPkg.sv */
package cpuPkg;

    // ==============================
    // Datapath types
    // ==============================
    typedef logic [63:0] dataWord;   // Register, ALU and memory value, also the PC
    typedef logic [31:0] instrWord;  // One fetched instruction
    typedef logic [4:0]  regAddr;    // Register number
    typedef logic [1:0]  aluControl; // ALU operation select
    typedef logic [3:0]  flagSet;    // {negative, zero, overflow, carry}

    localparam regAddr  zeroReg = 5'd31; // Reads zero, writes dropped
    localparam dataWord pcStep  = 64'd4; // Fetch increment

    // Bit positions inside flagSet
    localparam int flagN = 3;
    localparam int flagZ = 2;
    localparam int flagV = 1;
    localparam int flagC = 0;

    // ALU operations
    localparam aluControl aluAdd = 2'b00;
    localparam aluControl aluSub = 2'b01;
    localparam aluControl aluAnd = 2'b10;
    localparam aluControl aluOr  = 2'b11;

    // ==============================
    // Opcodes, instr[31:21]
    // ==============================
    // Short opcodes are padded with zeros where immediate bits sit
    localparam logic [10:0] opAddi  = 11'b10010001000; // Compare [10:1]
    localparam logic [10:0] opAdds  = 11'b10101011000;
    localparam logic [10:0] opSubs  = 11'b11101011000;
    localparam logic [10:0] opAnd   = 11'b10001010000;
    localparam logic [10:0] opOrr   = 11'b10101010000;
    localparam logic [10:0] opLdur  = 11'b11111000010;
    localparam logic [10:0] opStur  = 11'b11111000000;
    localparam logic [10:0] opB     = 11'b00010100000; // Compare [10:5]
    localparam logic [10:0] opBCond = 11'b01010100000; // Compare [10:3]

endpackage

/* verilog/controlUnit.sv */
`timescale 1ns/1ns
module controlUnit (
    input  logic [10:0]       opcode,
    output logic              reg2Loc,       // 1 reads Rm, 0 reads Rd as second operand
    output logic              aluSrc,        // 1 picks the immediate for operand B
    output logic              zeroExt,       // 1 zero-extends imm12, 0 sign-extends dAddr9
    output cpuPkg::aluControl aluOp,
    output logic              setFlags,
    output logic              memRead,
    output logic              memWrite,
    output logic              memToReg,
    output logic              regWrite,
    output logic              uncondBranch,
    output logic              condBranch,
    output logic              checkLessThan  // Condition field picks LT over EQ
);
    import cpuPkg::*;

    always_comb begin
        reg2Loc       = 1'b1;
        aluSrc        = 1'b0;
        zeroExt       = 1'b0;
        aluOp         = aluAdd;
        setFlags      = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        memToReg      = 1'b0;
        regWrite      = 1'b0;
        uncondBranch  = 1'b0;
        condBranch    = 1'b0;
        checkLessThan = 1'b0;
        if (opcode[10:1] == opAddi[10:1]) begin // imm12 overlaps bit 21
            aluSrc   = 1'b1;
            zeroExt  = 1'b1;
            regWrite = 1'b1;
        end else if (opcode == opAdds || opcode == opSubs) begin
            aluOp    = (opcode == opSubs) ? aluSub : aluAdd;
            setFlags = 1'b1;
            regWrite = 1'b1;
        end else if (opcode == opAnd || opcode == opOrr) begin
            aluOp    = (opcode == opOrr) ? aluOr : aluAnd;
            regWrite = 1'b1;
        end else if (opcode == opLdur) begin
            aluSrc   = 1'b1;                    // Base plus dAddr9
            memRead  = 1'b1;
            memToReg = 1'b1;
            regWrite = 1'b1;
        end else if (opcode == opStur) begin
            reg2Loc  = 1'b0;                    // Store data comes from Rt
            aluSrc   = 1'b1;
            memWrite = 1'b1;
        end else if (opcode[10:5] == opB[10:5]) begin
            uncondBranch = 1'b1;
        end else if (opcode[10:3] == opBCond[10:3]) begin
            condBranch    = 1'b1;
            checkLessThan = 1'b1;               // Qualified by the cond field
        end
    end

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ns
module registerFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddr  readAddrA,
    input  cpuPkg::regAddr  readAddrB,
    input  cpuPkg::regAddr  writeAddr,
    input  cpuPkg::dataWord writeData,
    input  logic            writeEn,
    output cpuPkg::dataWord readDataA,
    output cpuPkg::dataWord readDataB
);
    import cpuPkg::*;

    dataWord regs [32];                            // Entry 31 never written
    logic    writeLive;

    assign writeLive = writeEn && (writeAddr != zeroReg);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write goes straight to the readers
    function automatic dataWord readPort(regAddr addr);
        if (addr == zeroReg) return '0;
        if (writeLive && writeAddr == addr) return writeData;
        return regs[addr];
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

endmodule

/* verilog/forwardingUnit.sv */
`timescale 1ns/1ns
module forwardingUnit (
    input  cpuPkg::regAddr srcA,        // Rn in EX
    input  cpuPkg::regAddr srcB,        // Second read register in EX
    input  cpuPkg::regAddr memDest,
    input  logic           memRegWrite,
    input  cpuPkg::regAddr wbDest,
    input  logic           wbRegWrite,
    output logic [1:0]     forwardA,
    output logic [1:0]     forwardB
);
    import cpuPkg::*;

    // 00 register, 01 writeback value, 10 EX/MEM ALU result
    function automatic logic [1:0] pickSource(regAddr src);
        if (src == zeroReg) return 2'b00;
        if (memRegWrite && memDest == src) return 2'b10; // Newest wins
        if (wbRegWrite && wbDest == src) return 2'b01;
        return 2'b00;
    endfunction

    always_comb begin
        forwardA = pickSource(srcA);
        forwardB = pickSource(srcB);
    end

endmodule

/* verilog/executeUnit.sv */
`timescale 1ns/1ns
module executeUnit (
    input  cpuPkg::dataWord   regDataA,
    input  cpuPkg::dataWord   regDataB,
    input  logic [11:0]       imm12,
    input  logic [8:0]        dAddr9,
    input  logic              zeroExt,
    input  logic              aluSrc,
    input  cpuPkg::aluControl aluOp,
    input  logic [1:0]        forwardA,
    input  logic [1:0]        forwardB,
    input  cpuPkg::dataWord   memResult,  // EX/MEM ALU result
    input  cpuPkg::dataWord   wbResult,   // Writeback mux output
    output cpuPkg::dataWord   result,
    output cpuPkg::flagSet    flags,
    output cpuPkg::dataWord   storeData
);
    import cpuPkg::*;

    dataWord    opA;
    dataWord    opB;
    dataWord    immExt;
    dataWord    addB;       // opB, inverted for subtract
    logic [64:0] sum;       // Carry in bit 64
    logic       isArith;
    logic       isSub;

    // ==============================
    // Operand selection
    // ==============================
    always_comb begin
        case (forwardA)
            2'b01:   opA = wbResult;
            2'b10:   opA = memResult;
            default: opA = regDataA;
        endcase
        case (forwardB)
            2'b01:   storeData = wbResult;
            2'b10:   storeData = memResult;
            default: storeData = regDataB;
        endcase
    end

    assign immExt = zeroExt ? {52'b0, imm12} : {{55{dAddr9[8]}}, dAddr9};
    assign opB    = aluSrc ? immExt : storeData;   // Store data stays register sourced

    // ==============================
    // ALU
    // ==============================
    assign isSub   = (aluOp == aluSub);
    assign isArith = (aluOp == aluAdd) || isSub;
    assign addB    = isSub ? ~opB : opB;
    assign sum     = {1'b0, opA} + {1'b0, addB} + {64'b0, isSub}; // Two's complement sub

    always_comb begin
        case (aluOp)
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            default: result = sum[63:0];
        endcase
    end

    assign flags[flagN] = result[63];
    assign flags[flagZ] = (result == '0);
    assign flags[flagV] = isArith && (opA[63] == addB[63]) && (sum[63] != opA[63]);
    assign flags[flagC] = isArith && sum[64];   // Logic ops clear C

endmodule

/* verilog/branchUnit.sv */
`timescale 1ns/1ns
module branchUnit (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::dataWord memPc,        // PC of the instruction in MEM
    input  logic [25:0]     brAddr26,
    input  logic [18:0]     condAddr19,
    input  logic            uncondBranch,
    input  logic            condBranch,
    input  logic            checkLessThan,
    input  logic            setFlags,
    input  cpuPkg::flagSet  aluFlags,     // Flags carried in EX/MEM
    output cpuPkg::dataWord pc
);
    import cpuPkg::*;

    flagSet  flagReg;
    logic    condMet;
    logic    taken;
    dataWord offset;
    dataWord nextPc;

    // Flag register, written at the end of the MEM cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            flagReg <= '0;
        end else if (setFlags) begin
            flagReg <= aluFlags;
        end
    end

    // LT is N xor V
    assign condMet = checkLessThan ? (flagReg[flagN] ^ flagReg[flagV]) : flagReg[flagZ];
    assign taken   = uncondBranch || (condBranch && condMet);

    // Word offset, scaled to bytes
    assign offset = uncondBranch ? {{36{brAddr26[25]}}, brAddr26, 2'b00}
                                 : {{43{condAddr19[18]}}, condAddr19, 2'b00};
    assign nextPc = taken ? (memPc + offset) : (pc + pcStep);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* verilog/dataMemory.sv */
`timescale 1ns/1ns
module dataMemory #(
    parameter int dataMemWords = 64         // Power of two
) (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::dataWord address,        // Byte address
    input  logic            writeEn,
    input  logic            readEn,
    input  cpuPkg::dataWord writeData,
    output cpuPkg::dataWord readData
);
    import cpuPkg::*;

    localparam int idxBits = $clog2(dataMemWords);

    dataWord            mem [dataMemWords];
    logic [idxBits-1:0] index;

    assign index = address[idxBits+2:3];    // Word index, wraps at depth

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dataMemWords; i++) mem[i] <= '0;
        end else if (writeEn) begin
            mem[index] <= writeData;
        end
    end

    assign readData = readEn ? mem[index] : '0;

endmodule

/* verilog/armPipeline.sv */
`timescale 1ns/1ns
module armPipeline #(
    parameter int dataMemWords = 64
) (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::instrWord instr,        // From instruction ROM at instrAddr
    output cpuPkg::dataWord  instrAddr,
    output logic             regWriteEn,
    output cpuPkg::regAddr   regWriteAddr,
    output cpuPkg::dataWord  regWriteData,
    output logic             memWriteEn,
    output cpuPkg::dataWord  memWriteAddr,
    output cpuPkg::dataWord  memWriteData
);
    import cpuPkg::*;

    // IF/ID
    instrWord  instrId;
    dataWord   pcId;
    // ID
    logic      reg2Loc, checkLtDec, checkLtId;
    logic      aluSrcId, zeroExtId, setFlagsId, memReadId, memWriteId;
    logic      memToRegId, regWriteId, uncondId, condId;
    aluControl aluOpId;
    regAddr    readAddrBId;
    dataWord   rdDataAId, rdDataBId;
    // ID/EX
    logic      aluSrcEx, zeroExtEx, setFlagsEx, memReadEx, memWriteEx;
    logic      memToRegEx, regWriteEx, uncondEx, condEx, checkLtEx;
    aluControl aluOpEx;
    regAddr    rnEx, rbEx, rdEx;
    dataWord   rdDataAEx, rdDataBEx, pcEx;
    logic [11:0] imm12Ex;
    logic [8:0]  dAddr9Ex;
    logic [25:0] brAddr26Ex;
    logic [18:0] condAddr19Ex;
    // EX
    logic [1:0] forwardA, forwardB;
    dataWord   aluResultEx, storeDataEx;
    flagSet    flagsEx;
    // EX/MEM
    logic      setFlagsMem, memReadMem, memWriteMem, memToRegMem, regWriteMem;
    logic      uncondMem, condMem, checkLtMem;
    regAddr    rdMem;
    dataWord   aluResultMem, storeDataMem, pcMem, memDataMem;
    flagSet    flagsMem;
    logic [25:0] brAddr26Mem;
    logic [18:0] condAddr19Mem;
    // MEM/WB
    logic      memToRegWb, regWriteWb;
    regAddr    rdWb;
    dataWord   aluResultWb, memDataWb;

    // ==============================
    // IF and IF/ID
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            instrId <= '0;                      // Zero word decodes as no-op
            pcId    <= '0;
        end else begin
            instrId <= instr;
            pcId    <= instrAddr;
        end
    end

    // ==============================
    // ID
    // ==============================
    controlUnit control (
        .opcode(instrId[31:21]), .reg2Loc(reg2Loc), .aluSrc(aluSrcId), .zeroExt(zeroExtId),
        .aluOp(aluOpId), .setFlags(setFlagsId), .memRead(memReadId), .memWrite(memWriteId),
        .memToReg(memToRegId), .regWrite(regWriteId), .uncondBranch(uncondId),
        .condBranch(condId), .checkLessThan(checkLtDec)
    );

    assign readAddrBId = reg2Loc ? instrId[20:16] : instrId[4:0]; // Rm or Rt
    assign checkLtId   = checkLtDec && instrId[3];  // Cond LT 1011, EQ 0000

    registerFile regFile (
        .clk(clk), .reset(reset), .readAddrA(instrId[9:5]), .readAddrB(readAddrBId),
        .writeAddr(rdWb), .writeData(regWriteData), .writeEn(regWriteWb),
        .readDataA(rdDataAId), .readDataB(rdDataBId)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            {aluSrcEx, zeroExtEx, setFlagsEx, memReadEx, memWriteEx} <= '0;
            {memToRegEx, regWriteEx, uncondEx, condEx, checkLtEx}    <= '0;
            aluOpEx      <= aluAdd;
            {rnEx, rbEx, rdEx}           <= '0;
            {rdDataAEx, rdDataBEx, pcEx} <= '0;
            {imm12Ex, dAddr9Ex}          <= '0;
            {brAddr26Ex, condAddr19Ex}   <= '0;
        end else begin
            {aluSrcEx, zeroExtEx, setFlagsEx, memReadEx, memWriteEx} <=
                {aluSrcId, zeroExtId, setFlagsId, memReadId, memWriteId};
            {memToRegEx, regWriteEx, uncondEx, condEx, checkLtEx} <=
                {memToRegId, regWriteId, uncondId, condId, checkLtId};
            aluOpEx      <= aluOpId;
            rnEx         <= instrId[9:5];
            rbEx         <= readAddrBId;         // Forwarding compares the port actually read
            rdEx         <= instrId[4:0];
            rdDataAEx    <= rdDataAId;
            rdDataBEx    <= rdDataBId;
            pcEx         <= pcId;
            imm12Ex      <= instrId[21:10];
            dAddr9Ex     <= instrId[20:12];
            brAddr26Ex   <= instrId[25:0];
            condAddr19Ex <= instrId[23:5];
        end
    end

    // ==============================
    // EX
    // ==============================
    forwardingUnit forwarding (
        .srcA(rnEx), .srcB(rbEx), .memDest(rdMem), .memRegWrite(regWriteMem),
        .wbDest(rdWb), .wbRegWrite(regWriteWb), .forwardA(forwardA), .forwardB(forwardB)
    );

    executeUnit execute (
        .regDataA(rdDataAEx), .regDataB(rdDataBEx), .imm12(imm12Ex), .dAddr9(dAddr9Ex),
        .zeroExt(zeroExtEx), .aluSrc(aluSrcEx), .aluOp(aluOpEx), .forwardA(forwardA),
        .forwardB(forwardB), .memResult(aluResultMem), .wbResult(regWriteData),
        .result(aluResultEx), .flags(flagsEx), .storeData(storeDataEx)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            {setFlagsMem, memReadMem, memWriteMem, memToRegMem, regWriteMem} <= '0;
            {uncondMem, condMem, checkLtMem}           <= '0;
            {rdMem, flagsMem}                          <= '0;
            {aluResultMem, storeDataMem, pcMem}        <= '0;
            {brAddr26Mem, condAddr19Mem}               <= '0;
        end else begin
            {setFlagsMem, memReadMem, memWriteMem, memToRegMem, regWriteMem} <=
                {setFlagsEx, memReadEx, memWriteEx, memToRegEx, regWriteEx};
            {uncondMem, condMem, checkLtMem} <= {uncondEx, condEx, checkLtEx};
            rdMem         <= rdEx;
            flagsMem      <= flagsEx;
            aluResultMem  <= aluResultEx;
            storeDataMem  <= storeDataEx;
            pcMem         <= pcEx;
            brAddr26Mem   <= brAddr26Ex;
            condAddr19Mem <= condAddr19Ex;
        end
    end

    // ==============================
    // MEM
    // ==============================
    dataMemory #(.dataMemWords(dataMemWords)) dataMem (
        .clk(clk), .reset(reset), .address(aluResultMem), .writeEn(memWriteMem),
        .readEn(memReadMem), .writeData(storeDataMem), .readData(memDataMem)
    );

    branchUnit branch (
        .clk(clk), .reset(reset), .memPc(pcMem), .brAddr26(brAddr26Mem),
        .condAddr19(condAddr19Mem), .uncondBranch(uncondMem), .condBranch(condMem),
        .checkLessThan(checkLtMem), .setFlags(setFlagsMem), .aluFlags(flagsMem),
        .pc(instrAddr)
    );

    assign memWriteEn   = memWriteMem;
    assign memWriteAddr = aluResultMem;
    assign memWriteData = storeDataMem;

    always_ff @(posedge clk) begin
        if (reset) begin
            {memToRegWb, regWriteWb, rdWb}  <= '0;
            {aluResultWb, memDataWb}        <= '0;
        end else begin
            memToRegWb  <= memToRegMem;
            regWriteWb  <= regWriteMem;
            rdWb        <= rdMem;
            aluResultWb <= aluResultMem;
            memDataWb   <= memDataMem;
        end
    end

    // ==============================
    // WB
    // ==============================
    assign regWriteData = memToRegWb ? memDataWb : aluResultWb;
    assign regWriteEn   = regWriteWb;
    assign regWriteAddr = rdWb;

endmodule

/* sim/armPipelineTb.sv */
`timescale 1ns/1ns
module armPipelineTb;
    import cpuPkg::*;

    // ==============================
    // Golden file layout
    // ==============================
    localparam logic [63:0] kindProgram   = 64'h1;  // A byte address, B instruction
    localparam logic [63:0] kindWriteback = 64'h2;  // A register, B value
    localparam logic [63:0] kindStore     = 64'h3;  // A byte address, B data
    localparam int goldenWords = 768;               // 256 records of three words
    localparam int romWords    = 256;

    logic     clk = 1'b0;
    logic     reset;
    instrWord instr;
    dataWord  instrAddr;
    logic     regWriteEn;
    regAddr   regWriteAddr;
    dataWord  regWriteData;
    logic     memWriteEn;
    dataWord  memWriteAddr;
    dataWord  memWriteData;

    logic [63:0] golden [goldenWords];
    instrWord    rom [romWords];
    regAddr      expReg [$];                        // Writebacks in program order
    dataWord     expRegData [$];
    dataWord     expStAddr [$];                     // Stores in program order
    dataWord     expStData [$];

    int          programCount = 0;
    int          wbIdx = 0;
    int          stIdx = 0;
    int          cycleCount = 0;
    int          timeoutCycles = 40;
    int          testCount = 0;
    int          failCount = 0;
    int          errorCount = 0;
    bit          timedOut = 1'b0;

    armPipeline #(.dataMemWords(64)) DUT (
        .clk(clk), .reset(reset), .instr(instr), .instrAddr(instrAddr),
        .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
        .memWriteEn(memWriteEn), .memWriteAddr(memWriteAddr), .memWriteData(memWriteData)
    );

    always #2 clk = ~clk;                           // 4 ns period

    // Unfilled ROM words decode as no-ops
    function automatic instrWord readRom(dataWord addr);
        if (addr[63:10] != '0) return '0;
        return rom[addr[9:2]];
    endfunction

    always @(posedge clk) begin
        #1;
        instr = readRom(instrAddr);                 // PC only moves on the edge
    end

    // ==============================
    // Compare and report
    // ==============================
    task automatic checkReg(input string name, input regAddr got, input regAddr exp);
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkWord(input string name, input dataWord got, input dataWord exp);
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic reportTest(input string kind, input int index, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s %0d: ok", kind, index);
        end else begin
            failCount++;
            $display("%s %0d: mismatch", kind, index);
        end
    endtask

    task automatic loadGolden();
        logic [63:0] kind;
        logic [63:0] fieldA;
        logic [63:0] fieldB;
        for (int i = 0; i < goldenWords; i++) begin
            golden[i] = '0;
        end
        for (int i = 0; i < romWords; i++) begin
            rom[i] = '0;
        end
        $readmemh("sim/armPipelineGolden.txt", golden);
        for (int rec = 0; rec < goldenWords / 3; rec++) begin
            kind   = golden[3 * rec];
            fieldA = golden[3 * rec + 1];
            fieldB = golden[3 * rec + 2];
            if (kind == kindProgram) begin
                if (fieldA[63:10] != '0) begin
                    errorCount++;
                    $display("Program word at 0x%h lies beyond the instruction ROM", fieldA);
                end
                rom[fieldA[9:2]] = fieldB[31:0];
                programCount++;
            end else if (kind == kindWriteback) begin
                expReg.push_back(fieldA[4:0]);
                expRegData.push_back(fieldB);
            end else if (kind == kindStore) begin
                expStAddr.push_back(fieldA);
                expStData.push_back(fieldB);
            end else begin
                break;                              // First empty record ends the list
            end
        end
        if (programCount == 0 || expReg.size() == 0) begin
            errorCount++;
            $display("The golden file holds no program or no expected writebacks");
        end
    endtask

    // ==============================
    // Output monitor
    // ==============================
    always @(negedge clk) begin
        int errorsBefore;
        if (reset) begin
            if (regWriteEn !== 1'b0 || memWriteEn !== 1'b0) begin
                errorCount++;
                $display("A write strobe was high during reset at %0t ns", $time);
            end
        end else begin
            cycleCount++;
            if (regWriteEn) begin
                errorsBefore = errorCount;
                if (wbIdx >= expReg.size()) begin
                    errorCount++;
                    $display("Register X%0d was written after the last expected writeback",
                             regWriteAddr);
                end else begin
                    checkReg("regWriteAddr", regWriteAddr, expReg[wbIdx]);
                    checkWord("regWriteData", regWriteData, expRegData[wbIdx]);
                end
                reportTest("writeback", wbIdx, errorsBefore);
                wbIdx++;
            end
            if (memWriteEn) begin
                errorsBefore = errorCount;
                if (stIdx >= expStAddr.size()) begin
                    errorCount++;
                    $display("A store to 0x%h came after the last expected store", memWriteAddr);
                end else begin
                    checkWord("memWriteAddr", memWriteAddr, expStAddr[stIdx]);
                    checkWord("memWriteData", memWriteData, expStData[stIdx]);
                end
                reportTest("store", stIdx, errorsBefore);
                stIdx++;
            end
        end
    end

    // ==============================
    // Run control
    // ==============================
    initial begin
        void'($urandom(24026));
        reset = 1'b1;
        instr = '0;
        loadGolden();
        timeoutCycles = 4 * programCount + 40;      // Worst case fetch plus drain
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        while ((wbIdx < expReg.size() || stIdx < expStAddr.size())
               && cycleCount < timeoutCycles) begin
            @(posedge clk);
        end
        if (wbIdx < expReg.size() || stIdx < expStAddr.size()) begin
            timedOut = 1'b1;
            $display("Timeout after %0d cycles with %0d register writes and %0d stores missing",
                     cycleCount, expReg.size() - wbIdx, expStAddr.size() - stIdx);
        end else begin
            repeat (8) @(posedge clk);              // Catches strobes past the last expected one
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sim/armPipelineGolden.txt */
// Columns are kind, field A and field B, all in hex
// Kind 1 puts instruction B at byte address A, kind 2 expects B in register A, kind 3 a store of B at A
1 00 910017E1           // ADDI X1, XZR, #5
1 04 913FFFE2           // ADDI X2, XZR, #0xFFF
1 08 91004023           // ADDI X3, X1, #0x10
1 0C AB020064           // ADDS X4, X3, X2
1 10 8A020085           // AND X5, X4, X2
1 14 AA0100A6           // ORR X6, X5, X1
1 18 910103E7           // ADDI X7, XZR, #0x40
1 1C F81F80E4           // STUR X4, [X7, #-8]
1 20 F85F80E8           // LDUR X8, [X7, #-8]
1 24 910007E9           // ADDI X9, XZR, #1
1 28 AB01010A           // ADDS X10, X8, X1
1 2C 14000005           // B +5
1 30 910447EB           // ADDI X11, XZR, #0x111
1 34 91088BEC           // ADDI X12, XZR, #0x222
1 38 910CCFED           // ADDI X13, XZR, #0x333
1 3C 912EB7EE           // ADDI X14, XZR, #0xBAD skipped
1 40 91000FF0           // ADDI X16, XZR, #3
1 44 EB100211           // SUBS X17, X16, X16
1 48 5400014B           // B.LT +10 not taken
1 4C 540000A0           // B.EQ +5 taken
1 50 910063F2           // ADDI X18, XZR, #0x18
1 54 910067F3           // ADDI X19, XZR, #0x19
1 58 910083F4           // ADDI X20, XZR, #0x20
1 5C 912EB7F8           // ADDI X24, XZR, #0xBAD skipped
1 60 EB010219           // SUBS X25, X16, X1
1 64 540000A0           // B.EQ +5 not taken
1 68 540000AB           // B.LT +5 taken
1 6C 9100C3E0           // ADDI X0, XZR, #0x30
1 70 9100C7E1           // ADDI X1, XZR, #0x31
1 74 9100CBE2           // ADDI X2, XZR, #0x32
1 78 912EB7FD           // ADDI X29, XZR, #0xBAD skipped
1 7C 9101FBFE           // ADDI X30, XZR, #0x7E
3 38 1014               // STUR of X4
2 01 5
2 02 FFF
2 03 15
2 04 1014
2 05 14
2 06 15
2 07 40
2 08 1014               // Reloaded by LDUR
2 09 1
2 0A 1019
2 0B 111
2 0C 222
2 0D 333
2 10 3
2 11 0
2 12 18
2 13 19
2 14 20
2 19 FFFFFFFFFFFFFFFE
2 00 30
2 01 31
2 02 32
2 1E 7E

/* armPipeline.f */
verilog/cpuPkg.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/forwardingUnit.sv
verilog/executeUnit.sv
verilog/branchUnit.sv
verilog/dataMemory.sv
verilog/armPipeline.sv
sim/armPipelineTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= armPipelineTb
FILELIST  ?= armPipeline.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BINARY    := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
